//--- common/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int mem_depth = 1024;
    localparam int mem_addr_width = $clog2(mem_depth);

    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [2:0] funct3_lw = 3'b010; // SW shares this width code.

    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

endpackage

`default_nettype wire

//--- decode/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [rv_core_pkg::reg_addr_width-1:0]   rs1,
    input  logic [rv_core_pkg::reg_addr_width-1:0]   rs2,
    input  logic                                     wb_enable,
    input  logic [rv_core_pkg::reg_addr_width-1:0]   wb_rd,
    input  logic [rv_core_pkg::xlen-1:0]             wb_data,
    output logic [rv_core_pkg::xlen-1:0]             rs1_data,
    output logic [rv_core_pkg::xlen-1:0]             rs2_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [1:2**reg_addr_width-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // A write in the same cycle is passed straight through to the reader.
    assign rs1_data = (rs1 == '0) ? '0 : (wb_enable && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wb_enable && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     instr_valid,
    input  logic [rv_core_pkg::xlen-1:0]             instr_pc,
    input  logic [rv_core_pkg::xlen-1:0]             instr_word,
    input  logic                                     execute_busy,
    input  logic                                     wb_enable,
    input  logic [rv_core_pkg::reg_addr_width-1:0]   wb_rd,
    input  logic [rv_core_pkg::xlen-1:0]             wb_data,
    output logic                                     decode_stall,
    output logic                                     id_ex_valid,
    output logic [rv_core_pkg::xlen-1:0]             id_ex_pc,
    output logic [rv_core_pkg::xlen-1:0]             id_ex_rs1_data,
    output logic [rv_core_pkg::xlen-1:0]             id_ex_rs2_data,
    output logic [rv_core_pkg::xlen-1:0]             id_ex_imm,
    output logic [rv_core_pkg::reg_addr_width-1:0]   id_ex_rd,
    output rv_core_pkg::alu_op_t                     id_ex_alu_op,
    output logic                                     id_ex_use_imm,
    output logic                                     id_ex_load,
    output logic                                     id_ex_store,
    output logic                                     id_ex_writes
);
    import rv_core_pkg::*;

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic [xlen-1:0]           imm;
    alu_op_t                   alu_op;
    logic                      use_imm;
    logic                      is_load;
    logic                      is_store;
    logic                      writes;
    logic                      hazard;

    assign opcode = instr_word[6:0];
    assign rd = instr_word[11:7];
    assign funct3 = instr_word[14:12];
    assign rs1 = instr_word[19:15];
    assign rs2 = instr_word[24:20];
    assign funct7 = instr_word[31:25];

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .wb_enable (wb_enable),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    always_comb begin
        alu_op = alu_add;
        use_imm = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        writes = 1'b0;
        imm = {{20{instr_word[31]}}, instr_word[31:20]};
        case (opcode)
            opcode_op, opcode_op_imm: begin
                use_imm = (opcode == opcode_op_imm);
                writes = 1'b1;
                case (funct3)
                    funct3_add: alu_op = (!use_imm && funct7 == funct7_sub) ? alu_sub : alu_add;
                    funct3_slt: alu_op = alu_slt;
                    funct3_xor: alu_op = alu_xor;
                    funct3_or:  alu_op = alu_or;
                    funct3_and: alu_op = alu_and;
                    default:    writes = 1'b0; // Shifts and SLTU become no-ops.
                endcase
            end
            opcode_lui: begin
                alu_op = alu_pass_b;
                use_imm = 1'b1;
                writes = 1'b1;
                imm = {instr_word[31:12], 12'b0};
            end
            opcode_load: begin
                is_load = (funct3 == funct3_lw);
                writes = (funct3 == funct3_lw);
            end
            opcode_store: begin
                is_store = (funct3 == funct3_lw);
                imm = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
            end
            default: ;
        endcase
    end

    // A nonzero destination rules out a match on register zero.
    assign hazard = id_ex_valid && id_ex_rd != '0 && (rs1 == id_ex_rd || rs2 == id_ex_rd);
    assign decode_stall = instr_valid && (hazard || execute_busy);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex_valid <= 1'b0;
            id_ex_rd <= '0;
            id_ex_load <= 1'b0;
            id_ex_store <= 1'b0;
            id_ex_writes <= 1'b0;
        end else if (decode_stall) begin
            id_ex_valid <= 1'b0;
            id_ex_rd <= '0;
            id_ex_load <= 1'b0;
            id_ex_store <= 1'b0;
            id_ex_writes <= 1'b0;
        end else begin
            id_ex_valid <= instr_valid;
            id_ex_rd <= writes ? rd : '0;
            id_ex_load <= is_load;
            id_ex_store <= is_store;
            id_ex_writes <= writes;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_stall) begin
            id_ex_pc <= '0;
            id_ex_rs1_data <= '0;
            id_ex_rs2_data <= '0;
            id_ex_imm <= '0;
            id_ex_alu_op <= alu_add;
            id_ex_use_imm <= 1'b0;
        end else begin
            id_ex_pc <= instr_pc;
            id_ex_rs1_data <= rs1_data;
            id_ex_rs2_data <= rs2_data;
            id_ex_imm <= imm;
            id_ex_alu_op <= alu_op;
            id_ex_use_imm <= use_imm;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     run,
    input  logic                                     fetch_grant,
    input  logic                                     fetch_rsp,
    input  logic [rv_core_pkg::xlen-1:0]             fetch_rdata,
    input  logic                                     decode_stall,
    output logic                                     fetch_req,
    output logic [rv_core_pkg::mem_addr_width-1:0]   fetch_addr,
    output logic                                     instr_valid,
    output logic [rv_core_pkg::xlen-1:0]             instr_pc,
    output logic [rv_core_pkg::xlen-1:0]             instr_word
);
    import rv_core_pkg::*;

    logic [xlen-1:0] pc;
    logic            pending;

    // A new word is only asked for when the presented one leaves this cycle.
    assign fetch_req = run && !pending && !decode_stall;
    assign fetch_addr = pc[mem_addr_width+1:2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
            pending <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (fetch_grant) begin
                pc <= pc + 32'd4;
                pending <= 1'b1;
            end else if (fetch_rsp) begin
                pending <= 1'b0;
            end
            if (fetch_rsp) begin
                instr_valid <= 1'b1;
            end else if (!decode_stall) begin
                instr_valid <= 1'b0; // Decode took the word.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_rsp) begin
            instr_word <= fetch_rdata;
            instr_pc <= pc - 32'd4; // PC already moved past this word.
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     id_ex_valid,
    input  logic [rv_core_pkg::xlen-1:0]             id_ex_rs1_data,
    input  logic [rv_core_pkg::xlen-1:0]             id_ex_rs2_data,
    input  logic [rv_core_pkg::xlen-1:0]             id_ex_imm,
    input  logic [rv_core_pkg::reg_addr_width-1:0]   id_ex_rd,
    input  rv_core_pkg::alu_op_t                     id_ex_alu_op,
    input  logic                                     id_ex_use_imm,
    input  logic                                     id_ex_load,
    input  logic                                     id_ex_store,
    input  logic                                     id_ex_writes,
    input  logic                                     data_grant,
    input  logic                                     data_rsp,
    input  logic [rv_core_pkg::xlen-1:0]             data_rdata,
    output logic                                     execute_busy,
    output logic                                     data_req,
    output logic [rv_core_pkg::mem_addr_width-1:0]   data_addr,
    output logic                                     data_we,
    output logic [rv_core_pkg::xlen-1:0]             data_wdata,
    output logic                                     wb_enable,
    output logic [rv_core_pkg::reg_addr_width-1:0]   wb_rd,
    output logic [rv_core_pkg::xlen-1:0]             wb_data,
    output logic                                     retire_valid,
    output logic [rv_core_pkg::reg_addr_width-1:0]   retire_rd,
    output logic [rv_core_pkg::xlen-1:0]             retire_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0]           operand_b;
    logic [xlen-1:0]           alu_result;
    logic [xlen-1:0]           byte_addr;
    logic [reg_addr_width-1:0] mem_rd;
    logic                      mem_start, mem_busy, mem_wait;
    logic                      load_done, store_done, mem_done, alu_retire;

    assign operand_b = id_ex_use_imm ? id_ex_imm : id_ex_rs2_data;
    assign byte_addr = id_ex_rs1_data + id_ex_imm;

    always_comb begin
        case (id_ex_alu_op)
            alu_add: alu_result = id_ex_rs1_data + operand_b;
            alu_sub: alu_result = id_ex_rs1_data - operand_b;
            alu_and: alu_result = id_ex_rs1_data & operand_b;
            alu_or:  alu_result = id_ex_rs1_data | operand_b;
            alu_xor: alu_result = id_ex_rs1_data ^ operand_b;
            alu_slt: alu_result = {31'b0, $signed(id_ex_rs1_data) < $signed(operand_b)};
            default: alu_result = operand_b;
        endcase
    end

    assign mem_start = id_ex_valid && (id_ex_load || id_ex_store);
    assign store_done = data_grant && data_we;
    assign load_done = data_rsp && mem_wait;
    assign mem_done = store_done || load_done;
    assign execute_busy = mem_start || (mem_busy && !mem_done);
    assign data_req = mem_busy && !mem_wait;

    // Only the first cycle of a load or store sees its boundary entry.
    always_ff @(posedge clk) begin
        if (mem_start) begin
            data_addr <= byte_addr[mem_addr_width+1:2];
            data_we <= id_ex_store;
            data_wdata <= id_ex_rs2_data;
            mem_rd <= id_ex_rd;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_busy <= 1'b0;
            mem_wait <= 1'b0;
        end else if (mem_start) begin
            mem_busy <= 1'b1;
        end else if (mem_done) begin
            mem_busy <= 1'b0;
            mem_wait <= 1'b0;
        end else if (data_grant) begin
            mem_wait <= 1'b1; // Load granted, the word comes next cycle.
        end
    end

    assign alu_retire = id_ex_valid && id_ex_writes && !id_ex_load;
    assign wb_enable = alu_retire || load_done;
    assign wb_rd = load_done ? mem_rd : id_ex_rd;
    assign wb_data = load_done ? data_rdata : alu_result;

    assign retire_valid = wb_enable || store_done;
    assign retire_rd = store_done ? '0 : wb_rd;
    assign retire_data = store_done ? data_wdata : wb_data;

endmodule

`default_nettype wire

//--- verilog/memory_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module memory_arbiter (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     load_valid,
    input  logic [rv_core_pkg::mem_addr_width-1:0]   load_addr,
    input  logic [rv_core_pkg::xlen-1:0]             load_data,
    input  logic                                     data_req,
    input  logic [rv_core_pkg::mem_addr_width-1:0]   data_addr,
    input  logic                                     data_we,
    input  logic [rv_core_pkg::xlen-1:0]             data_wdata,
    input  logic                                     fetch_req,
    input  logic [rv_core_pkg::mem_addr_width-1:0]   fetch_addr,
    input  logic [rv_core_pkg::xlen-1:0]             mem_rdata,
    output logic                                     mem_en,
    output logic                                     mem_we,
    output logic [rv_core_pkg::mem_addr_width-1:0]   mem_addr,
    output logic [rv_core_pkg::xlen-1:0]             mem_wdata,
    output logic                                     load_grant,
    output logic                                     data_grant,
    output logic                                     fetch_grant,
    output logic                                     data_rsp,
    output logic                                     fetch_rsp,
    output logic [rv_core_pkg::xlen-1:0]             data_rdata,
    output logic [rv_core_pkg::xlen-1:0]             fetch_rdata
);
    import rv_core_pkg::*;

    logic [1:0] owner; // Bit 0 marks a data read, bit 1 a fetch.

    assign load_grant = load_valid;
    assign data_grant = data_req && !load_valid;
    assign fetch_grant = fetch_req && !load_valid && !data_req;

    assign mem_en = load_grant || data_grant || fetch_grant;
    assign mem_we = load_grant || (data_grant && data_we);
    assign mem_addr = load_grant ? load_addr : data_grant ? data_addr : fetch_addr;
    assign mem_wdata = load_grant ? load_data : data_wdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owner <= 2'b00;
        end else begin
            owner <= {fetch_grant, data_grant && !data_we};
        end
    end

    assign data_rsp = owner[0];
    assign fetch_rsp = owner[1];
    assign data_rdata = mem_rdata;
    assign fetch_rdata = mem_rdata;

endmodule

`default_nettype wire

//--- verilog/unified_memory.sv
`timescale 1ns/10ps
`default_nettype none

module unified_memory (
    input  logic                                     clk,
    input  logic                                     mem_en,
    input  logic                                     mem_we,
    input  logic [rv_core_pkg::mem_addr_width-1:0]   mem_addr,
    input  logic [rv_core_pkg::xlen-1:0]             mem_wdata,
    output logic [rv_core_pkg::xlen-1:0]             mem_rdata
);
    import rv_core_pkg::*;

    logic [xlen-1:0] mem_array [mem_depth];

    // Read data holds until the next read.
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem_array[mem_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     run,
    input  logic                                     load_valid,
    input  logic [rv_core_pkg::mem_addr_width-1:0]   load_addr,
    input  logic [rv_core_pkg::xlen-1:0]             load_data,
    output logic                                     retire_valid,
    output logic [rv_core_pkg::reg_addr_width-1:0]   retire_rd,
    output logic [rv_core_pkg::xlen-1:0]             retire_data
);
    import rv_core_pkg::*;

    logic                      fetch_req, fetch_grant, fetch_rsp;
    logic [mem_addr_width-1:0] fetch_addr;
    logic [xlen-1:0]           fetch_rdata;
    logic                      instr_valid, decode_stall, execute_busy;
    logic [xlen-1:0]           instr_pc, instr_word;

    logic                      id_ex_valid, id_ex_use_imm, id_ex_load, id_ex_store, id_ex_writes;
    logic [xlen-1:0]           id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    logic [reg_addr_width-1:0] id_ex_rd;
    alu_op_t                   id_ex_alu_op;

    logic                      wb_enable;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0]           wb_data;

    logic                      data_req, data_we, data_grant, data_rsp;
    logic [mem_addr_width-1:0] data_addr;
    logic [xlen-1:0]           data_wdata, data_rdata;

    logic                      mem_en, mem_we;
    logic [mem_addr_width-1:0] mem_addr;
    logic [xlen-1:0]           mem_wdata, mem_rdata;

    fetch_stage u_fetch_stage (.*);

    // The boundary PC is kept for waveform tracing only.
    decode_stage u_decode_stage (.*, .id_ex_pc());

    execute_stage u_execute_stage (.*);

    memory_arbiter u_memory_arbiter (.*, .load_grant());

    unified_memory u_unified_memory (.*);

endmodule

`default_nettype wire

//--- sim/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    localparam logic [6:0] op_reg_code = 7'b0110011;
    localparam logic [6:0] op_imm_code = 7'b0010011;
    localparam logic [6:0] lui_code = 7'b0110111;
    localparam logic [6:0] load_code = 7'b0000011;
    localparam logic [6:0] store_code = 7'b0100011;
    localparam int pad_words = 32; // Zero words after each program act as no-ops.

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        run = 1'b0;
    logic        load_valid = 1'b0;
    logic [9:0]  load_addr = '0;
    logic [31:0] load_data = '0;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] lfsr_state = 32'hfd44211d;
    logic [31:0] prog [$];
    int          test_start [$];
    int          test_len [$];
    logic        programs_ready = 1'b0;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [1024];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    int          test_num = 0;
    int          retire_count = 0;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
    endfunction

    // Collects n bits, one LFSR step for each.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic logic [2:0] pick_f3(input logic [2:0] r);
        case (r)
            3'd0, 3'd5: return 3'd0;
            3'd1, 3'd6: return 3'd2;
            3'd2, 3'd7: return 3'd4;
            3'd3:       return 3'd6;
            default:    return 3'd7;
        endcase
    endfunction

    function automatic logic [31:0] imm_instr(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] reg_instr(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg_code};
    endfunction

    function automatic logic [31:0] store_instr(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], store_code};
    endfunction

    function automatic logic [31:0] upper_instr(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, lui_code};
    endfunction

    // ISA result of the five ALU function codes.
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd4:    return a ^ b;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_programs();
        logic [4:0] prev;
        logic [4:0] rd;
        logic [2:0] f3;
        logic       sub;
        test_start.push_back(prog.size());
        for (int k = 0; k < 4; k++) begin
            prog.push_back(upper_instr(rand_reg(), 20'(rand_bits(20))));
        end
        for (int k = 0; k < 12; k++) begin
            prog.push_back(imm_instr(op_imm_code, pick_f3(3'(rand_bits(3))), rand_reg(),
                                     rand_reg(), 12'(rand_bits(12))));
        end
        test_start.push_back(prog.size());
        for (int k = 1; k <= 8; k++) begin
            prog.push_back(upper_instr(5'(k), {k[0], 19'(rand_bits(19))})); // Odd ones negative.
            prog.push_back(imm_instr(op_imm_code, 3'd0, 5'(k), 5'(k), 12'(rand_bits(12))));
        end
        for (int k = 0; k < 12; k++) begin
            f3 = pick_f3(3'(rand_bits(3)));
            sub = (f3 == 3'd0) && (rand_bits(1) != 32'd0);
            prog.push_back(reg_instr(sub ? 7'b0100000 : 7'd0, f3, 5'(9 + k),
                                     5'(1 + rand_bits(3)), 5'(1 + rand_bits(3))));
        end
        prog.push_back(reg_instr(7'd0, 3'd2, 5'd22, 5'd1, 5'd2));
        prog.push_back(reg_instr(7'd0, 3'd2, 5'd23, 5'd2, 5'd3));
        prog.push_back(reg_instr(7'd0, 3'd0, 5'd0, 5'd3, 5'd4));
        prog.push_back(reg_instr(7'd0, 3'd6, 5'd24, 5'd0, 5'd5));
        test_start.push_back(prog.size());
        prev = 5'd1;
        prog.push_back(imm_instr(op_imm_code, 3'd0, prev, 5'd0, 12'(rand_bits(12))));
        for (int k = 0; k < 12; k++) begin
            rd = rand_reg();
            if (k % 3 == 2) begin
                prog.push_back(reg_instr(7'd0, pick_f3(3'(rand_bits(3))), rd, prev, prev));
            end else begin
                prog.push_back(imm_instr(op_imm_code, pick_f3(3'(rand_bits(3))), rd, prev,
                                         12'(rand_bits(12))));
            end
            prev = rd;
        end
        test_start.push_back(prog.size());
        for (int k = 0; k < 6; k++) begin
            prog.push_back(upper_instr(5'(1 + k), 20'(rand_bits(20))));
            prog.push_back(imm_instr(op_imm_code, 3'd0, 5'(1 + k), 5'(1 + k), 12'(rand_bits(12))));
        end
        for (int k = 0; k < 6; k++) begin
            prog.push_back(store_instr(3'd2, 5'd0, 5'(1 + k), 12'(12'h700 + 4 * k)));
        end
        for (int k = 0; k < 6; k++) begin
            prog.push_back(imm_instr(load_code, 3'd2, 5'(10 + k), 5'd0, 12'(12'h714 - 4 * k)));
        end
        test_start.push_back(prog.size());
        prog.push_back(upper_instr(5'd1, 20'(rand_bits(20))));
        prog.push_back(imm_instr(op_imm_code, 3'd0, 5'd1, 5'd1, 12'(rand_bits(12))));
        prog.push_back(store_instr(3'd2, 5'd0, 5'd1, 12'h720));
        prog.push_back(imm_instr(load_code, 3'd2, 5'd2, 5'd0, 12'h720));
        prog.push_back(reg_instr(7'd0, 3'd0, 5'd3, 5'd2, 5'd1));
        prog.push_back(imm_instr(op_imm_code, 3'd0, 5'd9, 5'd0, 12'h700));
        prog.push_back(imm_instr(load_code, 3'd2, 5'd4, 5'd9, 12'h020));
        prog.push_back(imm_instr(op_imm_code, 3'd4, 5'd5, 5'd4, 12'(rand_bits(12))));
        prog.push_back(store_instr(3'd2, 5'd9, 5'd5, 12'h024));
        prog.push_back(imm_instr(load_code, 3'd2, 5'd6, 5'd9, 12'h024));
        prog.push_back(store_instr(3'd2, 5'd0, 5'd6, 12'h728)); // Stores the word just loaded.
        prog.push_back(imm_instr(load_code, 3'd2, 5'd7, 5'd0, 12'h728));
        prog.push_back(reg_instr(7'b0100000, 3'd0, 5'd8, 5'd7, 5'd2));
        test_start.push_back(prog.size());
        prog.push_back(imm_instr(op_imm_code, 3'd0, 5'd1, 5'd0, 12'(rand_bits(12))));
        prog.push_back(32'h0000_0000);
        prog.push_back(imm_instr(op_imm_code, 3'd6, 5'd2, 5'd1, 12'(rand_bits(12))));
        prog.push_back(32'h0020_8463); // BEQ
        prog.push_back(reg_instr(7'd0, 3'd1, 5'd3, 5'd1, 5'd2));
        prog.push_back(imm_instr(load_code, 3'd0, 5'd4, 5'd0, 12'h700));
        prog.push_back(32'h0000_056f); // JAL
        prog.push_back(imm_instr(op_imm_code, 3'd3, 5'd5, 5'd1, 12'h7ff));
        prog.push_back(reg_instr(7'd0, 3'd4, 5'd6, 5'd1, 5'd2));
        prog.push_back(32'hffff_ffff);
        prog.push_back(store_instr(3'd0, 5'd0, 5'd6, 12'h730)); // A byte store, so no write.
        prog.push_back(reg_instr(7'd0, 3'd7, 5'd7, 5'd6, 5'd1));
        for (int t = 0; t < 6; t++) begin
            test_len.push_back(((t == 5) ? prog.size() : test_start[t + 1]) - test_start[t]);
        end
    endtask

    // Runs the program on the ISA model and queues the expected retire events.
    task automatic model_program(input int start, input int len);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [2:0]  f3;
        logic        f3_ok;
        logic        wr;
        model_regs = '{default: '0};
        for (int i = start; i < start + len; i++) begin
            w = prog[i];
            f3 = w[14:12];
            a = model_regs[w[19:15]];
            b = model_regs[w[24:20]];
            f3_ok = (f3 == 3'd0) || (f3 == 3'd2) || (f3 == 3'd4) || (f3 >= 3'd6);
            wr = 1'b0;
            res = '0;
            if (w[6:0] == op_reg_code && f3_ok) begin
                res = alu_ref(f3, w[30], a, b);
                wr = 1'b1;
            end else if (w[6:0] == op_imm_code && f3_ok) begin
                res = alu_ref(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
                wr = 1'b1;
            end else if (w[6:0] == lui_code) begin
                res = {w[31:12], 12'd0};
                wr = 1'b1;
            end else if (w[6:0] == load_code && f3 == 3'd2) begin
                addr = a + {{20{w[31]}}, w[31:20]};
                res = model_mem[addr[11:2]];
                wr = 1'b1;
            end else if (w[6:0] == store_code && f3 == 3'd2) begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                model_mem[addr[11:2]] = b;
                exp_rd_q.push_back(5'd0);
                exp_data_q.push_back(b);
            end
            if (wr) begin
                exp_rd_q.push_back(w[11:7]);
                exp_data_q.push_back(res);
                if (w[11:7] != 5'd0) begin
                    model_regs[w[11:7]] = res;
                end
            end
        end
    endtask

    task automatic load_program(input int start, input int len);
        for (int i = 0; i < len + pad_words; i++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr <= 10'(i);
            load_data <= (i < len) ? prog[start + i] : 32'd0;
        end
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic run_test(input int t, input string name);
        int errors_before;
        int expected_count;
        errors_before = error_count;
        test_num = t;
        @(posedge clk);
        run <= 1'b0;
        load_program(test_start[t], test_len[t]);
        @(posedge clk);
        reset <= 1'b1;
        retire_count = 0;
        model_program(test_start[t], test_len[t]);
        expected_count = exp_rd_q.size();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        run <= 1'b1;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (24) @(posedge clk); // Any extra retire shows up here.
        assert (retire_count == expected_count) else begin
            $display("Test %0d retired %0d instructions where %0d were expected",
                     t, retire_count, expected_count);
            error_count++;
        end
        if (error_count == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test %0d %s: %s, %0d retires", t, name,
                 (error_count == errors_before) ? "ok" : "FAILED", retire_count);
    endtask

    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            retire_count++;
            assert (exp_rd_q.size() != 0) else begin
                $display("Test %0d retired an instruction beyond the end of its program",
                         test_num);
                error_count++;
            end
            if (exp_rd_q.size() != 0) begin
                exp_rd = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (retire_rd == exp_rd) else begin
                    $display("ERROR retire_rd expected 0x%h actual 0x%h", exp_rd, retire_rd);
                    error_count++;
                end
                assert (retire_data == exp_data) else begin
                    $display("ERROR retire_data expected 0x%h actual 0x%h",
                             exp_data, retire_data);
                    error_count++;
                end
            end
        end
    end

    initial begin
        wait (programs_ready);
        repeat (40 * prog.size() + 200) @(posedge clk);
        $display("Watchdog expired because the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        build_programs();
        programs_ready = 1'b1;
        run_test(0, "immediate ALU");
        run_test(1, "register ALU");
        run_test(2, "hazard stall");
        run_test(3, "store and load");
        run_test(4, "load use");
        run_test(5, "unsupported encodings");
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core.f
common/rv_core_pkg.sv
decode/register_file.sv
decode/decode_stage.sv
verilog/fetch_stage.sv
verilog/execute_stage.sv
verilog/memory_arbiter.sv
verilog/unified_memory.sv
verilog/rv_core_top.sv
sim/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run passed"
